//--- tb.f
hdl/bgsub_pkg.sv
hdl/bg_config_regs.sv
hdl/background_ram.sv
hdl/pixel_fetch.sv
hdl/adaptive_background.sv
hdl/motion_stats.sv
hdl/bgsub_top.sv
verification/bgsub_tb.sv

//--- verification/bgsub_tb.sv
/* random-stimulus testbench for bgsub_top, drives frames and register accesses and
   checks every result cycle against a background model kept in the testbench */
`timescale 1ns/1ps
`default_nettype none

module bgsub_tb
    import bgsub_pkg::*;
();

    localparam int ADDR_WIDTH     = 6;
    localparam int FRAME_PIXELS   = 48;
    localparam int SHIFT_LG2      = 2;
    localparam int FG_SHIFT_LG2   = 5;
    localparam int MAX_GAP        = 3;    // idle cycles ahead of a pixel, at most
    localparam int NUM_FRAMES     = 19;
    localparam int TIMEOUT_CYCLES =
        2 * NUM_FRAMES * (FRAME_PIXELS + MAX_GAP * FRAME_PIXELS + 6) + 100;
    localparam int RESULT_LAG     = 5;    // drive edge to the negedge showing its result

    // frame content kinds
    localparam int FR_RANDOM      = 0;
    localparam int FR_REPEAT      = 1;    // same pixels as the previous frame
    localparam int FR_GREY        = 2;
    localparam int FR_DARK_BRIGHT = 3;    // near 0 or near 255

    logic       clk;
    logic       rst;
    logic       pix_active;
    logic       pix_sof;
    pixel_t     pix_live;
    logic       reg_wr;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wdata;
    reg_data_t  reg_rdata;
    fg_out_t    fg;

    // ========================================================================
    // model state
    // ========================================================================
    pixel_t     bg_model [2**ADDR_WIDTH];
    pixel_t     frame_buf [FRAME_PIXELS];
    fg_out_t    exp_fg [16];              // expected result per cycle, ring by cycle
    logic       model_enable;
    logic       cap_armed;
    logic       cap_frame;
    threshold_t model_thresh;
    int         frame_flags;
    count_t     exp_fg_count;
    count_t     exp_frames;
    integer     seed;
    int         cyc = 0;

    bgsub_top #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .FRAME_PIXELS (FRAME_PIXELS),
        .SHIFT_LG2    (SHIFT_LG2),
        .FG_SHIFT_LG2 (FG_SHIFT_LG2)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .pix_active (pix_active),
        .pix_sof    (pix_sof),
        .pix_live   (pix_live),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .fg         (fg)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t: %s, got %0h expected %0h", $time, what, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic pixel_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // reference arithmetic for one accepted pixel, result goes into the ring
    task automatic predict_pixel(input pixel_t live, input logic first, input int addr,
                                 input int slot);
        int      diff;
        int      mag;
        int      delta;
        int      nb;
        fg_out_t res;
        res = '0;
        if (model_enable) begin
            if (first) begin
                cap_frame   = cap_armed;      // capture takes the whole next frame
                cap_armed   = 1'b0;
                frame_flags = 0;
            end
            res.valid = 1'b1;
            res.sof   = first;
            if (cap_frame) begin
                bg_model[addr] = live;        // plain store, never foreground
            end else begin
                diff = int'(live) - int'(bg_model[addr]);
                mag  = (diff < 0) ? -diff : diff;
                res.flag  = mag > int'(model_thresh);
                res.pixel = res.flag ? live : 8'd0;
                delta = res.flag ? (diff >>> FG_SHIFT_LG2) : (diff >>> SHIFT_LG2);
                nb    = int'(bg_model[addr]) + delta;
                if (nb < 0)        nb = 0;    // clamp low
                else if (nb > 255) nb = 255;  // clamp high
                bg_model[addr] = pixel_t'(nb);
                frame_flags = frame_flags + int'(res.flag);
            end
        end
        exp_fg[slot] = res;
    endtask

    task automatic drive_pixel(input pixel_t live, input logic first, input int addr);
        @(posedge clk);
        pix_active <= 1'b1;
        pix_sof    <= first;
        pix_live   <= live;
        predict_pixel(live, first, addr, (cyc + RESULT_LAG) % 16);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        pix_active <= 1'b0;
        pix_sof    <= 1'b0;
        pix_live   <= rand_byte();            // junk, must be ignored
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
        if (addr == REG_CTRL) begin
            model_enable = data[0];
            if (data[1]) cap_armed = 1'b1;
        end
        if (addr == REG_THRESH) model_thresh = data[8:0];
    endtask

    // combinational readback, sampled mid-cycle
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        data = reg_rdata;
    endtask

    // one frame with random gaps, idle tail, then statistics readback
    task automatic run_frame(input int mode);
        int        i;
        int        r;
        int        gap;
        pixel_t    live;
        reg_data_t rdata;
        for (i = 0; i < FRAME_PIXELS; i++) begin
            r   = $random(seed);
            gap = (r[3:0] < 4'd11) ? 0 : int'(r[5:4]);   // up to MAX_GAP
            if (i > 0) repeat (gap) drive_idle();
            case (mode)
                FR_REPEAT:      live = frame_buf[i];
                FR_GREY:        live = 8'd120 + {4'd0, r[11:8]};
                FR_DARK_BRIGHT: live = r[12] ? {4'hf, r[11:8]} : {4'h0, r[11:8]};
                default:        live = r[23:16];
            endcase
            frame_buf[i] = live;
            drive_pixel(live, i == 0, i);
        end
        repeat (6) drive_idle();                  // lets the pipeline drain
        if (model_enable) begin
            exp_frames   = exp_frames + 1'b1;
            exp_fg_count = count_t'(frame_flags);
        end
        cap_frame = 1'b0;
        read_reg(REG_FRAMES, rdata);
        check_value("frame count", rdata, exp_frames);
        read_reg(REG_FG_COUNT, rdata);
        check_value("foreground count", rdata, exp_fg_count);
    endtask

    // ========================================================================
    // result check, every cycle against the ring
    // ========================================================================
    always @(negedge clk) begin : result_check
        int slot;
        if (!rst) begin
            slot = cyc % 16;
            check_value("fg.valid", fg.valid, exp_fg[slot].valid);
            check_value("fg.sof", fg.sof, exp_fg[slot].sof);
            check_value("fg.flag", fg.flag, exp_fg[slot].flag);
            check_value("fg.pixel", fg.pixel, exp_fg[slot].pixel);
            exp_fg[slot] = '0;
        end
    end

    initial begin : stimulus
        reg_data_t rdata;
        reg_data_t frames_before;
        int        i;
        rst          = 1'b1;
        pix_active   = 1'b0;
        pix_sof      = 1'b0;
        pix_live     = '0;
        reg_wr       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        seed         = 76;
        model_enable = 1'b0;
        cap_armed    = 1'b0;
        cap_frame    = 1'b0;
        model_thresh = '0;
        frame_flags  = 0;
        exp_fg_count = '0;
        exp_frames   = '0;
        for (i = 0; i < 16; i++) exp_fg[i] = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // capture frame 0, identical frame 1 shows no foreground
        write_reg(REG_THRESH, 16'd0);
        write_reg(REG_CTRL, 16'h3);
        read_reg(REG_CTRL, rdata);
        check_value("ctrl after arming", rdata, 16'h3);
        run_frame(FR_RANDOM);
        read_reg(REG_CTRL, rdata);
        check_value("ctrl after capture frame", rdata, 16'h1);
        run_frame(FR_REPEAT);
        read_reg(REG_FG_COUNT, rdata);
        check_value("count on captured scene", rdata, 16'd0);

        // random scenes, new threshold each frame
        repeat (6) begin
            write_reg(REG_THRESH, reg_data_t'(rand_byte() & 8'h7f));
            read_reg(REG_THRESH, rdata);
            check_value("threshold readback", rdata, reg_data_t'(model_thresh));
            run_frame(FR_RANDOM);
        end

        // mid-grey background pulled toward both ends at both rates
        write_reg(REG_CTRL, 16'h3);
        run_frame(FR_GREY);
        for (i = 0; i < 4; i++) begin
            write_reg(REG_THRESH, i[0] ? 16'd200 : 16'd20);
            run_frame(FR_DARK_BRIGHT);
        end

        // stream blocked while disabled, background kept
        frames_before = exp_frames;
        write_reg(REG_CTRL, 16'h0);
        repeat (2) run_frame(FR_RANDOM);
        read_reg(REG_FRAMES, rdata);
        check_value("frames while disabled", rdata, frames_before);
        write_reg(REG_CTRL, 16'h1);
        write_reg(REG_THRESH, 16'd40);
        repeat (2) run_frame(FR_RANDOM);

        // second capture through the control register
        write_reg(REG_THRESH, 16'd0);
        write_reg(REG_CTRL, 16'h3);
        read_reg(REG_CTRL, rdata);
        check_value("ctrl after second arming", rdata, 16'h3);
        run_frame(FR_RANDOM);
        read_reg(REG_CTRL, rdata);
        check_value("ctrl after second capture", rdata, 16'h1);
        run_frame(FR_REPEAT);
        read_reg(REG_FG_COUNT, rdata);
        check_value("count after second capture", rdata, 16'd0);

        repeat (8) drive_idle();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/bgsub_top.sv
/* adaptive background subtraction subsystem, pixel stream in and foreground results
   out, configured through a small register bus */
`timescale 1ns/1ps
`default_nettype none

module bgsub_top
    import bgsub_pkg::*;
#(
    parameter int ADDR_WIDTH   = 17,
    parameter int FRAME_PIXELS = 76800,   // at most 2^ADDR_WIDTH
    parameter int SHIFT_LG2    = 4,
    parameter int FG_SHIFT_LG2 = 8
) (
    input  wire logic      clk,
    input  wire logic      rst,
    // pixel stream
    input  wire logic      pix_active,
    input  wire logic      pix_sof,
    input  wire pixel_t    pix_live,
    // register bus
    input  wire logic      reg_wr,
    input  wire reg_addr_t reg_addr,
    input  wire reg_data_t reg_wdata,
    output reg_data_t      reg_rdata,
    // results, 4 cycles after the input pixel
    output fg_out_t        fg
);

    bg_cfg_t               cfg;
    logic                  frame_done;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    pixel_t                rd_data;
    fetch_beat_t           beat;
    logic [ADDR_WIDTH-1:0] beat_addr;
    threshold_t            beat_thresh;
    bg_wr_t                bg_wr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    count_t                fg_count;
    count_t                frame_count;

    bg_config_regs i_regs (
        .clk, .rst, .reg_wr, .reg_addr, .reg_wdata,
        .pix_sof, .frame_done, .fg_count, .frame_count,
        .cfg, .reg_rdata
    );

    pixel_fetch #(.ADDR_WIDTH(ADDR_WIDTH), .FRAME_PIXELS(FRAME_PIXELS)) i_fetch (
        .clk, .rst, .cfg, .pix_active, .pix_sof, .pix_live, .rd_data,
        .rd_en, .rd_addr, .beat, .beat_addr, .beat_thresh, .frame_done
    );

    background_ram #(.ADDR_WIDTH(ADDR_WIDTH)) i_ram (
        .clk, .rd_en, .rd_addr, .wr(bg_wr), .wr_addr, .rd_data
    );

    adaptive_background #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .SHIFT_LG2    (SHIFT_LG2),
        .FG_SHIFT_LG2 (FG_SHIFT_LG2)
    ) i_bg (
        .clk, .rst, .beat, .beat_addr, .beat_thresh,
        .wr(bg_wr), .wr_addr, .fg
    );

    motion_stats #(.FRAME_PIXELS(FRAME_PIXELS)) i_stats (
        .clk, .rst, .fg, .fg_count, .frame_count
    );

endmodule

`default_nettype wire

//--- hdl/motion_stats.sv
/* per-frame foreground statistics, counts flagged results over FRAME_PIXELS valid
   results and holds the last completed count for readback */
`timescale 1ns/1ps
`default_nettype none

module motion_stats
    import bgsub_pkg::*;
#(
    parameter int FRAME_PIXELS = 76800
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire fg_out_t fg,
    output count_t       fg_count,      // last completed frame
    output count_t       frame_count    // completed frames, wraps
);

    localparam count_t LAST_PIX = count_t'(FRAME_PIXELS - 1);

    count_t valid_cnt;     // results seen in the running frame
    count_t flag_cnt;      // flagged results in the running frame
    count_t valid_base;
    count_t flag_base;

    // sof restarts the frame even if counts got out of step
    assign valid_base = fg.sof ? '0 : valid_cnt;
    assign flag_base  = fg.sof ? '0 : flag_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_cnt   <= '0;
            flag_cnt    <= '0;
            fg_count    <= '0;
            frame_count <= '0;
        end else if (fg.valid) begin
            if (valid_base == LAST_PIX) begin    // last pixel of frame
                fg_count    <= flag_base + count_t'(fg.flag);
                frame_count <= frame_count + 1'b1;
                valid_cnt   <= '0;
                flag_cnt    <= '0;
            end else begin
                valid_cnt <= valid_base + 1'b1;
                flag_cnt  <= flag_base + count_t'(fg.flag);
            end
        end
    end

    a_sof_at_zero: assert property (@(posedge clk) disable iff (rst)
        (fg.valid && fg.sof) |-> valid_cnt == '0)
        else $error("result sof with a frame still running");

    a_sof_needs_valid: assert property (@(posedge clk) disable iff (rst)
        fg.sof |-> fg.valid)
        else $error("result sof without valid");

endmodule

`default_nettype wire

//--- hdl/adaptive_background.sv
/* 3-stage foreground decision and dual-rate background update with write-back,
   fed by pixel_fetch, fixed latency of 3 cycles from beat to fg and RAM write */
`timescale 1ns/1ps
`default_nettype none

module adaptive_background
    import bgsub_pkg::*;
#(
    parameter int ADDR_WIDTH   = 17,
    parameter int SHIFT_LG2    = 4,    // background rate 1/2^n
    parameter int FG_SHIFT_LG2 = 8     // foreground rate 1/2^n
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire fetch_beat_t           beat,
    input  wire logic [ADDR_WIDTH-1:0] beat_addr,
    input  wire threshold_t            beat_thresh,
    output bg_wr_t                     wr,
    output logic [ADDR_WIDTH-1:0]      wr_addr,
    output fg_out_t                    fg
);

    // ========================================================================
    // pipeline registers
    // ========================================================================
    // stage 1, latched beat
    logic                  act1, sof1, load1;
    pixel_t                live1, bg1;
    threshold_t            thresh1;
    logic [ADDR_WIDTH-1:0] addr1;

    // stage 2, difference and decision
    logic                  act2, sof2, load2;
    pixel_t                live2, bg2;
    logic                  fg2;
    logic signed [8:0]     diff2;
    logic [ADDR_WIDTH-1:0] addr2;

    // stage 3, new background and outputs
    logic                  act3, sof3, load3;
    pixel_t                live3, newbg3;
    logic                  fg3;
    logic [ADDR_WIDTH-1:0] addr3;

    // combinational
    logic signed [8:0]     diff1;
    logic [8:0]            abs1;
    logic                  fg1;
    logic signed [8:0]     delta2;
    logic signed [9:0]     sum2;     // one extra bit so +255 overflow is visible
    pixel_t                newbg2;
    logic                  flag3;

    // stage 1 math
    assign diff1 = $signed({1'b0, live1}) - $signed({1'b0, bg1});   // -255..255
    assign abs1  = diff1[8] ? 9'(-diff1) : diff1;
    assign fg1   = abs1 > thresh1;

    // stage 2 math, slow rate lets a stopped object fade into the background
    assign delta2 = fg2 ? (diff2 >>> FG_SHIFT_LG2) : (diff2 >>> SHIFT_LG2);
    assign sum2   = $signed({2'b00, bg2}) + $signed({delta2[8], delta2});

    // clamp to 0..255
    always_comb begin
        if (sum2[9])      newbg2 = 8'd0;     // negative
        else if (sum2[8]) newbg2 = 8'd255;   // above full scale
        else              newbg2 = sum2[7:0];
    end

    // ========================================================================
    // control bits, reset
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            act1 <= 1'b0;
            act2 <= 1'b0;
            act3 <= 1'b0;
            sof1 <= 1'b0;
            sof2 <= 1'b0;
            sof3 <= 1'b0;
        end else begin
            act1 <= beat.active;
            act2 <= act1;
            act3 <= act2;
            sof1 <= beat.sof;
            sof2 <= sof1;
            sof3 <= sof2;
        end
    end

    // data path, no reset
    always_ff @(posedge clk) begin
        load1   <= beat.load;
        live1   <= beat.live;
        bg1     <= beat.bg;
        thresh1 <= beat_thresh;
        addr1   <= beat_addr;

        load2   <= load1;
        live2   <= live1;
        bg2     <= bg1;
        fg2     <= fg1;
        diff2   <= diff1;
        addr2   <= addr1;

        load3   <= load2;
        live3   <= live2;
        newbg3  <= newbg2;
        fg3     <= fg2;
        addr3   <= addr2;
    end

    // ========================================================================
    // outputs
    // ========================================================================
    // capture frame compares against stale RAM, so no foreground is reported there
    assign flag3 = act3 && fg3 && !load3;

    assign wr      = '{en: act3, data: load3 ? live3 : newbg3};
    assign wr_addr = addr3;
    assign fg      = '{valid: act3, sof: act3 && sof3, flag: flag3,
                       pixel: flag3 ? live3 : 8'd0};

    a_wr_matches_valid: assert property (@(posedge clk) disable iff (rst)
        wr.en == fg.valid)
        else $error("write enable and result valid differ");

    a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        beat.active |-> ##3 fg.valid)
        else $error("beat did not produce a result 3 cycles later");

endmodule

`default_nettype wire

//--- hdl/pixel_fetch.sv
/* front stage of the pipeline, generates the pixel address, reads the background RAM
   and lines the live pixel up with the read data one cycle later */
`timescale 1ns/1ps
`default_nettype none

module pixel_fetch
    import bgsub_pkg::*;
#(
    parameter int ADDR_WIDTH   = 17,
    parameter int FRAME_PIXELS = 76800
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire bg_cfg_t               cfg,
    input  wire logic                  pix_active,
    input  wire logic                  pix_sof,
    input  wire pixel_t                pix_live,
    input  wire pixel_t                rd_data,
    output logic                       rd_en,
    output logic [ADDR_WIDTH-1:0]      rd_addr,
    output fetch_beat_t                beat,
    output logic [ADDR_WIDTH-1:0]      beat_addr,
    output threshold_t                 beat_thresh,
    output logic                       frame_done    // last pixel accepted this cycle
);

    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(FRAME_PIXELS - 1);

    logic                  accept;
    logic [ADDR_WIDTH-1:0] addr_cnt;     // address of the next non-sof pixel
    logic [ADDR_WIDTH-1:0] cur_addr;
    logic                  active_q;
    logic                  sof_q;
    logic                  load_q;
    pixel_t                live_q;

    assign accept     = pix_active && cfg.enable;     // enable low blocks the stream here
    assign cur_addr   = pix_sof ? '0 : addr_cnt;
    assign frame_done = accept && (cur_addr == LAST_ADDR);

    assign rd_en   = accept;
    assign rd_addr = cur_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_cnt <= '0;
        end else if (accept) begin
            addr_cnt <= frame_done ? '0 : cur_addr + 1'b1;
        end
    end

    // ========================================================================
    // alignment registers, one cycle like the RAM read
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            sof_q    <= 1'b0;
        end else begin
            active_q <= accept;
            sof_q    <= accept && pix_sof;
        end
    end

    always_ff @(posedge clk) begin
        load_q      <= cfg.capture;
        live_q      <= pix_live;
        beat_addr   <= cur_addr;
        beat_thresh <= cfg.threshold;
    end

    assign beat = '{active: active_q, sof: sof_q, load: load_q, live: live_q, bg: rd_data};

    a_addr_in_frame: assert property (@(posedge clk) disable iff (rst)
        accept |-> int'(cur_addr) < FRAME_PIXELS)
        else $error("pixel address beyond frame");

    // previous frame must be complete before a new one starts
    a_sof_at_frame_start: assert property (@(posedge clk) disable iff (rst)
        (accept && pix_sof) |-> addr_cnt == '0)
        else $error("sof before previous frame completed");

endmodule

`default_nettype wire

//--- hdl/background_ram.sv
/* background frame store, one registered read port for fetch and one write port
   for the pipeline write-back */
`timescale 1ns/1ps
`default_nettype none

module background_ram
    import bgsub_pkg::*;
#(
    parameter int ADDR_WIDTH = 17
) (
    input  wire logic                  clk,
    input  wire logic                  rd_en,
    input  wire logic [ADDR_WIDTH-1:0] rd_addr,
    input  wire bg_wr_t                wr,
    input  wire logic [ADDR_WIDTH-1:0] wr_addr,
    output pixel_t                     rd_data
);

    localparam int DEPTH = 2**ADDR_WIDTH;

    pixel_t mem [DEPTH];   // contents undefined until a capture frame

    // write-back port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // read port, data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/bg_config_regs.sv
/* control registers for the background subtraction core, with capture sequencing
   and readback of the per-frame statistics from motion_stats */
`timescale 1ns/1ps
`default_nettype none

module bg_config_regs
    import bgsub_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      reg_wr,        // one-cycle write strobe
    input  wire reg_addr_t reg_addr,
    input  wire reg_data_t reg_wdata,
    input  wire logic      pix_sof,
    input  wire logic      frame_done,    // last pixel of frame accepted at fetch
    input  wire count_t    fg_count,
    input  wire count_t    frame_count,
    output bg_cfg_t        cfg,
    output reg_data_t      reg_rdata
);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ARMED,       // waiting for the next frame start
        CAP_ACTIVE       // current frame is being stored
    } cap_state_t;

    cap_state_t cap_state;
    logic       enable;
    threshold_t threshold;
    logic       sof_accept;    // frame start that fetch will take
    logic       capture;

    assign sof_accept = pix_sof && enable;

    // capture rises together with the accepted sof so the first pixel is loaded too
    assign capture = (cap_state == CAP_ACTIVE) ||
                     ((cap_state == CAP_ARMED) && sof_accept);

    assign cfg = '{enable: enable, threshold: threshold, capture: capture};

    // ========================================================================
    // writable registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b0;
            threshold <= '0;
        end else if (reg_wr) begin
            if (reg_addr == REG_CTRL)   enable    <= reg_wdata[0];
            if (reg_addr == REG_THRESH) threshold <= reg_wdata[8:0];
        end
    end

    // capture sequencing, a write of bit 1 arms it
    always_ff @(posedge clk) begin
        if (rst) begin
            cap_state <= CAP_IDLE;
        end else begin
            case (cap_state)
                CAP_IDLE:   if (reg_wr && reg_addr == REG_CTRL && reg_wdata[1])
                                cap_state <= CAP_ARMED;
                CAP_ARMED:  if (sof_accept) cap_state <= CAP_ACTIVE;
                CAP_ACTIVE: if (frame_done) cap_state <= CAP_IDLE;
                default:    cap_state <= CAP_IDLE;
            endcase
        end
    end

    // readback mux
    always_comb begin
        case (reg_addr)
            REG_CTRL:     reg_rdata = {14'd0, cap_state != CAP_IDLE, enable};
            REG_THRESH:   reg_rdata = {7'd0, threshold};
            REG_FG_COUNT: reg_rdata = fg_count;
            default:      reg_rdata = frame_count;
        endcase
    end

    // a frame that both starts and ends in one pixel would leave capture stuck active
    a_no_done_at_arm: assert property (@(posedge clk) disable iff (rst)
        (cap_state == CAP_ARMED && pix_sof) |-> !frame_done)
        else $error("frame_done together with sof while capture armed");

endmodule

`default_nettype wire

//--- hdl/bgsub_pkg.sv
/* shared types, stream structs and register offsets for the background subtraction core
   imported by every RTL module of the subsystem */
`default_nettype none

package bgsub_pkg;

    // ========================================================================
    // scalar types
    // ========================================================================
    typedef logic [7:0]  pixel_t;       // one grayscale pixel
    typedef logic [8:0]  threshold_t;   // compared against |live - bg|
    typedef logic [15:0] count_t;       // per-frame foreground count
    typedef logic [1:0]  reg_addr_t;    // register offset
    typedef logic [15:0] reg_data_t;    // register data

    // ========================================================================
    // structs between blocks
    // ========================================================================
    typedef struct packed {
        logic       enable;     // stream accepted at fetch
        threshold_t threshold;
        logic       capture;    // high for the whole capture frame
    } bg_cfg_t;

    typedef struct packed {
        logic   active;     // pixel present
        logic   sof;        // first pixel of frame
        logic   load;       // capture frame, store live as-is
        pixel_t live;
        pixel_t bg;         // RAM read data
    } fetch_beat_t;

    typedef struct packed {
        logic   en;
        pixel_t data;
    } bg_wr_t;

    typedef struct packed {
        logic   valid;
        logic   sof;
        logic   flag;       // foreground decision
        pixel_t pixel;      // live pixel when foreground, else zero
    } fg_out_t;

    // register map
    localparam reg_addr_t REG_CTRL     = 2'd0;  // bit 0 enable, bit 1 capture
    localparam reg_addr_t REG_THRESH   = 2'd1;
    localparam reg_addr_t REG_FG_COUNT = 2'd2;  // read only
    localparam reg_addr_t REG_FRAMES   = 2'd3;  // read only, wraps at 2^16

endpackage

`default_nettype wire
